// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = eeprom_ctrl_tb
FILELIST   = eeprom_ctrl.f
OBJ        = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ)

// File: eeprom_ctrl.f
+incdir+hdl
hdl/i2c_pkg.sv
hdl/eeprom_pkg.sv
hdl/eeprom_cmd_regs.sv
hdl/eeprom_sequencer.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_ctrl_top.sv
tests/eeprom_slave_model.sv
tests/eeprom_ctrl_assertions.sv
tests/eeprom_ctrl_tb.sv

// File: hdl/eeprom_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_cmd_regs (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        wr,
    input  wire                        rd,
    input  wire [`EEPROM_ADDR_W-1:0]   addr,
    input  wire [`EEPROM_DATA_W-1:0]   wdata,
    input  wire                        finish,
    input  wire [`EEPROM_DATA_W-1:0]   read_byte,
    input  wire                        slave_nack,
    output logic                       go,
    output eeprom_pkg::host_op_t       op,
    output logic [`EEPROM_ADDR_W-1:0]  req_addr,
    output logic [`EEPROM_DATA_W-1:0]  req_wdata,
    output logic                       busy,
    output logic                       done,
    output logic [`EEPROM_DATA_W-1:0]  rdata,
    output logic                       nack_err
);

    logic accept;

    assign accept = (wr | rd) & ~busy;  // strobes while busy are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            go       <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            go   <= accept;
            done <= finish;
            if (accept)
                busy <= 1'b1;
            else if (finish)
                busy <= 1'b0;
            if (finish)
                nack_err <= slave_nack;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op        <= wr ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;  // wr wins
            req_addr  <= addr;
            req_wdata <= wdata;
        end
        if (finish)
            rdata <= read_byte;
    end

endmodule

`default_nettype wire

// File: hdl/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_ctrl_top (
    input  wire                       CLK,
    input  wire                       RESET,
    input  wire                       wr,
    input  wire                       rd,
    input  wire [`EEPROM_ADDR_W-1:0]  addr,
    input  wire [`EEPROM_DATA_W-1:0]  wdata,
    input  wire                       sda_in,
    output wire                       busy,
    output wire                       done,
    output wire [`EEPROM_DATA_W-1:0]  rdata,
    output wire                       nack_err,
    output wire                       scl,
    output wire                       sda_low
);

    wire go;
    wire finish;
    wire slave_nack;
    wire eeprom_pkg::host_op_t op;
    wire [`EEPROM_ADDR_W-1:0] req_addr;
    wire [`EEPROM_DATA_W-1:0] req_wdata;
    wire [`EEPROM_DATA_W-1:0] read_byte;
    wire cmd_valid;
    wire cmd_done;
    wire ack_seen;
    wire master_nack;
    wire i2c_pkg::bit_cmd_t cmd;
    wire [`EEPROM_DATA_W-1:0] tx_byte;
    wire [`EEPROM_DATA_W-1:0] rx_byte;

    eeprom_cmd_regs u_regs (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .finish(finish), .read_byte(read_byte), .slave_nack(slave_nack),
        .go(go), .op(op), .req_addr(req_addr), .req_wdata(req_wdata),
        .busy(busy), .done(done), .rdata(rdata), .nack_err(nack_err)
    );

    eeprom_sequencer u_seq (
        .CLK(CLK), .RESET(RESET), .go(go), .op(op), .req_addr(req_addr),
        .req_wdata(req_wdata), .cmd_done(cmd_done), .rx_byte(rx_byte),
        .ack_seen(ack_seen), .cmd_valid(cmd_valid), .cmd(cmd), .tx_byte(tx_byte),
        .master_nack(master_nack), .finish(finish), .read_byte(read_byte),
        .slave_nack(slave_nack)
    );

    i2c_bit_engine u_engine (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd(cmd), .tx_byte(tx_byte),
        .master_nack(master_nack), .sda_in(sda_in), .cmd_done(cmd_done),
        .rx_byte(rx_byte), .ack_seen(ack_seen), .scl(scl), .sda_low(sda_low)
    );

endmodule

`default_nettype wire

// File: hdl/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } host_op_t;

    // one state per bus step of a transaction
    typedef enum logic [3:0] {
        SEQ_IDLE    = 4'd0,
        SEQ_START   = 4'd1,
        SEQ_CTRL_WR = 4'd2,  // control byte, r/w bit low
        SEQ_ADDR    = 4'd3,
        SEQ_DATA    = 4'd4,
        SEQ_RESTART = 4'd5,
        SEQ_CTRL_RD = 4'd6,  // control byte, r/w bit high
        SEQ_READ    = 4'd7,
        SEQ_STOP    = 4'd8
    } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_sequencer (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        go,
    input  wire eeprom_pkg::host_op_t  op,
    input  wire [`EEPROM_ADDR_W-1:0]   req_addr,
    input  wire [`EEPROM_DATA_W-1:0]   req_wdata,
    input  wire                        cmd_done,
    input  wire [`EEPROM_DATA_W-1:0]   rx_byte,
    input  wire                        ack_seen,
    output logic                       cmd_valid,
    output i2c_pkg::bit_cmd_t          cmd,
    output logic [`EEPROM_DATA_W-1:0]  tx_byte,
    output logic                       master_nack,
    output logic                       finish,
    output logic [`EEPROM_DATA_W-1:0]  read_byte,
    output logic                       slave_nack
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t next_state;
    i2c_pkg::bit_cmd_t next_cmd;
    logic [`EEPROM_DATA_W-1:0] next_tx;
    logic [`EEPROM_ADDR_W-`EEPROM_DATA_W-1:0] block;

    assign block = req_addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W];

    // any missing slave ack jumps straight to stop
    always_comb
    begin
        next_state = state;
        case (state)
            eeprom_pkg::SEQ_IDLE:
                if (go)
                    next_state = eeprom_pkg::SEQ_START;
            eeprom_pkg::SEQ_START:
                if (cmd_done)
                    next_state = eeprom_pkg::SEQ_CTRL_WR;
            eeprom_pkg::SEQ_CTRL_WR:
                if (cmd_done)
                    next_state = ack_seen ? eeprom_pkg::SEQ_ADDR : eeprom_pkg::SEQ_STOP;
            eeprom_pkg::SEQ_ADDR:
                if (cmd_done)
                begin
                    if (!ack_seen)
                        next_state = eeprom_pkg::SEQ_STOP;
                    else if (op == eeprom_pkg::OP_WRITE)
                        next_state = eeprom_pkg::SEQ_DATA;
                    else
                        next_state = eeprom_pkg::SEQ_RESTART;
                end
            eeprom_pkg::SEQ_DATA:
                if (cmd_done)
                    next_state = eeprom_pkg::SEQ_STOP;
            eeprom_pkg::SEQ_RESTART:
                if (cmd_done)
                    next_state = eeprom_pkg::SEQ_CTRL_RD;
            eeprom_pkg::SEQ_CTRL_RD:
                if (cmd_done)
                    next_state = ack_seen ? eeprom_pkg::SEQ_READ : eeprom_pkg::SEQ_STOP;
            eeprom_pkg::SEQ_READ:
                if (cmd_done)
                    next_state = eeprom_pkg::SEQ_STOP;
            eeprom_pkg::SEQ_STOP:
                if (cmd_done)
                    next_state = eeprom_pkg::SEQ_IDLE;
            default:
                next_state = eeprom_pkg::SEQ_IDLE;
        endcase
    end

    // command and byte issued on entry to a state
    always_comb
    begin
        next_cmd = i2c_pkg::CMD_WRITE_BYTE;
        next_tx  = '0;
        case (next_state)
            eeprom_pkg::SEQ_START,
            eeprom_pkg::SEQ_RESTART:
                next_cmd = i2c_pkg::CMD_START;
            eeprom_pkg::SEQ_CTRL_WR:
                next_tx = {`EEPROM_DEV_CODE, block, 1'b0};
            eeprom_pkg::SEQ_ADDR:
                next_tx = req_addr[`EEPROM_DATA_W-1:0];  // low word address
            eeprom_pkg::SEQ_DATA:
                next_tx = req_wdata;
            eeprom_pkg::SEQ_CTRL_RD:
                next_tx = {`EEPROM_DEV_CODE, block, 1'b1};
            eeprom_pkg::SEQ_READ:
                next_cmd = i2c_pkg::CMD_READ_BYTE;
            eeprom_pkg::SEQ_STOP:
                next_cmd = i2c_pkg::CMD_STOP;
            default:
                next_cmd = i2c_pkg::CMD_WRITE_BYTE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= eeprom_pkg::SEQ_IDLE;
            cmd_valid  <= 1'b0;
            finish     <= 1'b0;
            slave_nack <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            cmd_valid <= (next_state != state) && (next_state != eeprom_pkg::SEQ_IDLE);
            finish    <= (state == eeprom_pkg::SEQ_STOP) && cmd_done;
            if (go && state == eeprom_pkg::SEQ_IDLE)
                slave_nack <= 1'b0;
            else if (cmd_done && !ack_seen)
                slave_nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        cmd         <= next_cmd;
        tx_byte     <= next_tx;
        master_nack <= (next_state == eeprom_pkg::SEQ_READ);  // single byte, so always last
        if (state == eeprom_pkg::SEQ_READ && cmd_done)
            read_byte <= rx_byte;
    end

endmodule

`default_nettype wire

// File: hdl/eeprom_settings.svh
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// word address width, top three bits are the block select
`define EEPROM_ADDR_W 11

// byte width on the host port and on the bus
`define EEPROM_DATA_W 8

// system clocks per quarter of an SCL period
`define I2C_QUARTER_CLKS 2

// device type code in the upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

`endif

// File: hdl/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module i2c_bit_engine (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        cmd_valid,
    input  wire i2c_pkg::bit_cmd_t     cmd,
    input  wire [`EEPROM_DATA_W-1:0]   tx_byte,
    input  wire                        master_nack,
    input  wire                        sda_in,
    output logic                       cmd_done,
    output logic [`EEPROM_DATA_W-1:0]  rx_byte,
    output logic                       ack_seen,
    output logic                       scl,
    output logic                       sda_low
);

    localparam int Q   = `I2C_QUARTER_CLKS;
    localparam int QW  = (Q > 1) ? $clog2(Q) : 1;
    localparam int BW  = $clog2(`EEPROM_DATA_W);
    localparam int MSB = `EEPROM_DATA_W - 1;

    i2c_pkg::engine_state_t state;
    logic [QW-1:0] qcnt;
    logic [1:0] phase;       // quarter within the bit
    logic [BW-1:0] bit_cnt;
    logic [MSB:0] shreg;
    logic reading;
    logic nack_hold;
    logic tick;

    assign tick = (qcnt == QW'(Q - 1));

    // scl is low in quarters 3 and 0, high in 1 and 2
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= i2c_pkg::ENG_IDLE;
            qcnt     <= '0;
            phase    <= 2'd0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (state == i2c_pkg::ENG_IDLE)
            begin
                if (cmd_valid)
                begin
                    qcnt  <= '0;
                    phase <= 2'd0;
                    scl   <= 1'b0;
                    case (cmd)
                        i2c_pkg::CMD_START:
                        begin
                            state   <= i2c_pkg::ENG_START;
                            sda_low <= 1'b0;  // release so SDA is high before it falls
                        end
                        i2c_pkg::CMD_WRITE_BYTE:
                        begin
                            state   <= i2c_pkg::ENG_BYTE;
                            sda_low <= ~tx_byte[MSB];
                        end
                        i2c_pkg::CMD_READ_BYTE:
                        begin
                            state   <= i2c_pkg::ENG_BYTE;
                            sda_low <= 1'b0;
                        end
                        i2c_pkg::CMD_STOP:
                        begin
                            state   <= i2c_pkg::ENG_STOP;
                            sda_low <= 1'b1;
                        end
                    endcase
                end
            end
            else if (!tick)
                qcnt <= qcnt + QW'(1);
            else
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0:
                        scl <= 1'b1;
                    2'd1:
                        // middle of scl high
                        if (state == i2c_pkg::ENG_START)
                            sda_low <= 1'b1;
                        else if (state == i2c_pkg::ENG_STOP)
                            sda_low <= 1'b0;
                    2'd2:
                        if (state != i2c_pkg::ENG_STOP)
                            scl <= 1'b0;  // stop leaves the bus idle with scl high
                    default:
                        case (state)
                            i2c_pkg::ENG_BYTE:
                                if (bit_cnt == BW'(MSB))
                                begin
                                    state   <= i2c_pkg::ENG_ACK;
                                    sda_low <= reading & ~nack_hold;  // our ack after a read
                                end
                                else if (!reading)
                                    sda_low <= ~shreg[MSB-1];
                            default:
                            begin
                                state    <= i2c_pkg::ENG_IDLE;
                                cmd_done <= 1'b1;
                            end
                        endcase
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == i2c_pkg::ENG_IDLE)
        begin
            bit_cnt   <= '0;
            shreg     <= tx_byte;
            reading   <= (cmd == i2c_pkg::CMD_READ_BYTE);
            nack_hold <= master_nack;
            ack_seen  <= 1'b1;  // start and stop have no ack
        end
        else if (tick)
        begin
            if (phase == 2'd1 && state == i2c_pkg::ENG_BYTE && reading)
                shreg <= {shreg[MSB-1:0], sda_in};
            if (phase == 2'd1 && state == i2c_pkg::ENG_ACK)
                ack_seen <= reading | ~sda_in;
            if (phase == 2'd3 && state == i2c_pkg::ENG_BYTE)
            begin
                bit_cnt <= bit_cnt + BW'(1);
                if (!reading)
                    shreg <= {shreg[MSB-1:0], 1'b0};
            end
            if (phase == 2'd3 && state == i2c_pkg::ENG_ACK)
                rx_byte <= shreg;
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // byte-level commands accepted by the bit engine
    typedef enum logic [1:0] {
        CMD_START      = 2'd0,  // also used for the repeated start
        CMD_WRITE_BYTE = 2'd1,
        CMD_READ_BYTE  = 2'd2,
        CMD_STOP       = 2'd3
    } bit_cmd_t;

    // bit engine phases
    typedef enum logic [2:0] {
        ENG_IDLE  = 3'd0,
        ENG_START = 3'd1,
        ENG_BYTE  = 3'd2,  // eight data bits
        ENG_ACK   = 3'd3,  // ninth bit
        ENG_STOP  = 3'd4
    } engine_state_t;

endpackage

`default_nettype wire

// File: tests/eeprom_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_assertions (
    input wire                         CLK,
    input wire                         RESET,
    input wire                         wr,
    input wire                         rd,
    input wire                         busy,
    input wire                         done,
    input wire                         scl,
    input wire                         sda_in,
    input wire i2c_pkg::engine_state_t eng_state
);

    logic pending;  // accepted strobe not yet answered
    int failures = 0;  // assertion failures seen

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pending <= 1'b0;
        else if ((wr | rd) && !busy)
            pending <= 1'b1;
        else if (done)
            pending <= 1'b0;
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else
        begin
            failures++;
            $error("done held longer than one cycle");
        end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_in) && scl && $past(scl)) |->
        (eng_state == i2c_pkg::ENG_START || eng_state == i2c_pkg::ENG_STOP))
        else
        begin
            failures++;
            $error("sda moved while scl high outside start or stop");
        end

    a_busy_reset: assert property (@(posedge CLK) $fell(RESET) |-> !busy)
        else
        begin
            failures++;
            $error("busy high right after reset");
        end

    a_done_req: assert property (@(posedge CLK) disable iff (RESET) done |-> pending)
        else
        begin
            failures++;
            $error("done without an accepted request");
        end

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assertions u_assertions (
    .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .busy(busy), .done(done),
    .scl(scl), .sda_in(sda_in), .eng_state(u_engine.state)
);

`default_nettype wire

// File: tests/eeprom_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_ctrl_tb;

    localparam int BIT_CLKS   = 4 * `I2C_QUARTER_CLKS;
    localparam int WRITE_CLKS = 29 * BIT_CLKS + 2 * 5;  // five commands
    localparam int READ_CLKS  = 39 * BIT_CLKS + 2 * 7;  // seven commands
    localparam int WATCH_CLKS = WRITE_CLKS + 20;  // room for a whole second write

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
    logic refuse;
    wire busy;
    wire done;
    wire nack_err;
    wire scl;
    wire sda_low;
    wire slave_pull;
    wire sda;
    wire [`EEPROM_DATA_W-1:0] rdata;

    integer errors = 0;
    integer passed = 0;
    integer failed = 0;
    integer cycles = 0;
    integer cycle_limit = 0;
    logic test_bad;

    string t_name[$];
    string t_op[$];
    logic [`EEPROM_ADDR_W-1:0] t_addr[$];
    logic [`EEPROM_DATA_W-1:0] t_data[$];
    logic [`EEPROM_DATA_W-1:0] t_exp[$];
    logic t_refuse[$];

    assign sda = ~(sda_low | slave_pull);  // open-drain wire with pull-up

    eeprom_ctrl_top uut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .sda_in(sda), .busy(busy), .done(done), .rdata(rdata), .nack_err(nack_err),
        .scl(scl), .sda_low(sda_low)
    );

    eeprom_slave_model u_slave (.scl(scl), .sda(sda), .refuse(refuse), .sda_pull(slave_pull));

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: no result after %0d clock cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic report(input string name);
        if (test_bad)
        begin
            failed++;
            $display("%s: failed", name);
        end
        else
        begin
            passed++;
            $display("%s: passed", name);
        end
    endtask

    task automatic load_tests;
        integer fd;
        integer r;
        integer n;
        integer rf;
        string line;
        string nm;
        string opn;
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [`EEPROM_DATA_W-1:0] d;
        logic [`EEPROM_DATA_W-1:0] ex;
        fd = $fopen("tests/eeprom_ctrl_testdata.txt", "r");
        if (fd == 0)
            $display("cannot open the test data file");
        else
        begin
            while (!$feof(fd))
            begin
                r = $fgets(line, fd);
                if (r == 0 || line.len() == 0 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%s %s %h %h %d %h", nm, opn, a, d, rf, ex);
                if (n != 6)
                    continue;
                t_name.push_back(nm);
                t_op.push_back(opn);
                t_addr.push_back(a);
                t_data.push_back(d);
                t_refuse.push_back(rf != 0);
                t_exp.push_back(ex);
            end
            $fclose(fd);
        end
    endtask

    task automatic strobe(input logic is_read, input logic [`EEPROM_ADDR_W-1:0] a,
                          input logic [`EEPROM_DATA_W-1:0] d);
        @(negedge CLK);
        addr  = a;
        wdata = d;
        rd    = is_read;
        wr    = ~is_read;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic run_test(input int i);
        integer extra_done;
        test_bad = 1'b0;
        refuse   = t_refuse[i];
        strobe(t_op[i] == "rd", t_addr[i], t_data[i]);
        if (t_op[i] == "wrb")
        begin
            while (!busy)
                @(negedge CLK);
            strobe(1'b0, t_addr[i], t_exp[i]);  // should be dropped
        end
        while (!done)
            @(negedge CLK);
        compare({t_name[i], " nack_err"}, 32'(t_refuse[i]), 32'(nack_err));
        if (t_op[i] == "rd" && !t_refuse[i])
            compare({t_name[i], " rdata"}, 32'(t_exp[i]), 32'(rdata));
        if (t_op[i] == "wrb")
        begin
            extra_done = 0;
            repeat (WATCH_CLKS)
            begin
                @(negedge CLK);
                if (done)
                    extra_done++;
            end
            compare({t_name[i], " extra done"}, 32'd0, 32'(extra_done));
        end
        refuse = 1'b0;
        report(t_name[i]);
    endtask

    initial
    begin
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        refuse = 1'b0;
        load_tests();
        if (t_name.size() == 0)
        begin
            $display("no test cases were read from the data file");
            errors++;
        end
        // each test fits in one read plus the busy watch, doubled for margin
        cycle_limit = 20 + 2 * (READ_CLKS + WATCH_CLKS) * t_name.size();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        @(negedge CLK);
        test_bad = 1'b0;
        compare("idle scl", 32'd1, 32'(scl));
        compare("idle sda_low", 32'd0, 32'(sda_low));
        compare("idle busy", 32'd0, 32'(busy));
        report("idle_after_reset");

        for (int i = 0; i < t_name.size(); i++)
            run_test(i);

        if (uut.u_assertions.failures != 0)
        begin
            $display("%0d assertion failures", uut.u_assertions.failures);
            errors += uut.u_assertions.failures;
        end
        $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/eeprom_ctrl_testdata.txt
# name op addr data refuse expect (hex except refuse)
# op wr, rd or wrb; wrb strobes again while busy with the expect byte
fresh_read rd 155 00 0 ff
wr_blk0 wr 023 a5 0 00
wr_blk5 wr 523 3c 0 00
wr_blk7 wr 723 c3 0 00
rd_blk0 rd 023 00 0 a5
rd_blk5 rd 523 00 0 3c
rd_blk7 rd 723 00 0 c3
refuse_wr wr 023 11 1 00
after_refuse rd 023 00 0 a5
refuse_rd rd 523 00 1 00
busy_strobe wrb 2ff 5a 0 99
after_busy rd 2ff 00 0 5a
wr_top wr 7ff 01 0 00
rd_top rd 7ff 00 0 01

// File: tests/eeprom_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_slave_model (
    input  wire  scl,
    input  wire  sda,
    input  wire  refuse,
    output logic sda_pull
);

    localparam int M_IDLE = 0;
    localparam int M_CTRL = 1;
    localparam int M_ADDR = 2;
    localparam int M_DATA = 3;
    localparam int M_READ = 4;

    logic [7:0] mem [0:2047];
    logic [7:0] shift;
    logic [2:0] blk;
    logic [7:0] waddr;
    logic scl_q;
    logic sda_q;
    int bitn;
    int mode;
    int pend;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;  // erased part
        sda_pull = 1'b0;
        shift    = 8'h00;
        blk      = 3'd0;
        waddr    = 8'h00;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
        bitn     = 0;
        mode     = M_IDLE;
        pend     = M_IDLE;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            // start or stop, scl held high
            if (sda === 1'b0)
            begin
                mode = M_CTRL;
                bitn = 0;
            end
            else
                mode = M_IDLE;
            sda_pull = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b0)
        begin
            if (bitn < 8)
                shift = {shift[6:0], sda};
            bitn++;
        end
        else if (scl === 1'b0 && scl_q === 1'b1)
        begin
            if (bitn == 8)
            begin
                sda_pull = 1'b0;  // read data released for the master ack
                pend     = M_IDLE;
                case (mode)
                    M_CTRL:
                        if (shift[7:4] == `EEPROM_DEV_CODE && !refuse)
                        begin
                            sda_pull = 1'b1;
                            blk      = shift[3:1];
                            pend     = shift[0] ? M_READ : M_ADDR;
                        end
                    M_ADDR:
                    begin
                        waddr    = shift;
                        sda_pull = 1'b1;
                        pend     = M_DATA;
                    end
                    M_DATA:
                    begin
                        mem[{blk, waddr}] = shift;
                        sda_pull          = 1'b1;
                    end
                    default:
                        pend = M_IDLE;
                endcase
            end
            else if (bitn == 9)
            begin
                bitn     = 0;
                mode     = pend;
                sda_pull = (mode == M_READ) && !mem[{blk, waddr}][7];
            end
            else if (mode == M_READ && bitn >= 1 && bitn < 8)
                sda_pull = !mem[{blk, waddr}][3'(7 - bitn)];
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire
